// ==== common/axi4l_pkg.sv ====
package axi4l_pkg;

    // Register map and bus sizes
    localparam int addr_wid = 32;
    localparam int data_wid = 32;
    localparam int strb_wid = data_wid / 8;
    localparam int reg_count = 8;
    localparam int reg_idx_wid = $clog2(reg_count);
    localparam logic [data_wid-1:0] reg_id_value = 32'h4158_4c31;  // "AXL1"

    // AXI response codes
    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // Channel payloads
    typedef struct packed {
        logic [addr_wid-1:0] addr;
        logic [2:0]          prot;
    } ax_t;  // AW and AR

    typedef struct packed {
        logic [data_wid-1:0] data;
        logic [strb_wid-1:0] strb;
    } w_t;

    typedef struct packed {
        resp_t resp;
    } b_t;

    typedef struct packed {
        logic [data_wid-1:0] data;
        resp_t               resp;
    } r_t;

    // Register slice configuration
    typedef enum logic [1:0] {
        slice_bypass,
        slice_light,
        slice_full
    } slice_config_t;

    // Peripheral reset delay, indexed by slice_config_t
    localparam int reset_stages [3] = '{0, 1, 1};

endpackage : axi4l_pkg

// ==== reg_slice/axi4l_skid_buffer.sv ====
`timescale 1ns/1ns

module axi4l_skid_buffer
    import axi4l_pkg::*;
#(
    parameter type payload_t = logic,
    parameter slice_config_t cfg = slice_full
) (
    input  logic     aclk,
    input  logic     rst_n,
    input  payload_t in,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out,
    output logic     out_valid,
    input  logic     out_ready
);

    generate
        if (cfg == slice_full) begin : g_full
            payload_t main_q;
            payload_t spare_q;
            logic     main_valid;
            logic     spare_valid;
            logic     main_load;
            logic     in_xfer;

            assign in_ready  = !spare_valid;  // Registered ready
            assign in_xfer   = in_valid && in_ready;
            assign main_load = !main_valid || out_ready;
            assign out       = main_q;
            assign out_valid = main_valid;

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    main_valid  <= 1'b0;
                    spare_valid <= 1'b0;
                end else if (main_load) begin
                    main_valid  <= spare_valid || in_xfer;
                    spare_valid <= 1'b0;
                end else if (in_xfer) begin
                    spare_valid <= 1'b1;  // Output stalled, park item
                end
            end

            always_ff @(posedge aclk) begin
                if (main_load) begin
                    main_q <= spare_valid ? spare_q : in;  // Oldest item first
                end else if (in_xfer) begin
                    spare_q <= in;
                end
            end
        end else if (cfg == slice_light) begin : g_light
            payload_t hold_q;
            logic     hold_valid;

            assign in_ready  = !hold_valid;
            assign out       = hold_q;
            assign out_valid = hold_valid;

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    hold_valid <= 1'b0;
                end else if (!hold_valid) begin
                    hold_valid <= in_valid;
                end else if (out_ready) begin
                    hold_valid <= 1'b0;
                end
            end

            always_ff @(posedge aclk) begin
                if (!hold_valid) begin
                    hold_q <= in;
                end
            end
        end else begin : g_bypass
            assign in_ready  = out_ready;
            assign out       = in;
            assign out_valid = in_valid;
        end
    endgenerate

endmodule : axi4l_skid_buffer

// ==== reg_slice/axi4l_reg_slice.sv ====
`timescale 1ns/1ns

module axi4l_reg_slice
    import axi4l_pkg::*;
#(
    parameter slice_config_t cfg = slice_full
) (
    input  logic aclk,
    input  logic rst_n,
    // Controller side
    input  ax_t  aw,
    input  logic aw_valid,
    output logic aw_ready,
    input  w_t   w,
    input  logic w_valid,
    output logic w_ready,
    output b_t   b,
    output logic b_valid,
    input  logic b_ready,
    input  ax_t  ar,
    input  logic ar_valid,
    output logic ar_ready,
    output r_t   r,
    output logic r_valid,
    input  logic r_ready,
    // Peripheral side
    output ax_t  p_aw,
    output logic p_aw_valid,
    input  logic p_aw_ready,
    output w_t   p_w,
    output logic p_w_valid,
    input  logic p_w_ready,
    input  b_t   p_b,
    input  logic p_b_valid,
    output logic p_b_ready,
    output ax_t  p_ar,
    output logic p_ar_valid,
    input  logic p_ar_ready,
    input  r_t   p_r,
    input  logic p_r_valid,
    output logic p_r_ready,
    output logic p_rst_n
);

    axi4l_skid_buffer #(.payload_t(ax_t), .cfg(cfg)) i_skid_aw (
        .aclk(aclk), .rst_n(rst_n),
        .in(aw), .in_valid(aw_valid), .in_ready(aw_ready),
        .out(p_aw), .out_valid(p_aw_valid), .out_ready(p_aw_ready)
    );

    axi4l_skid_buffer #(.payload_t(w_t), .cfg(cfg)) i_skid_w (
        .aclk(aclk), .rst_n(rst_n),
        .in(w), .in_valid(w_valid), .in_ready(w_ready),
        .out(p_w), .out_valid(p_w_valid), .out_ready(p_w_ready)
    );

    axi4l_skid_buffer #(.payload_t(ax_t), .cfg(cfg)) i_skid_ar (
        .aclk(aclk), .rst_n(rst_n),
        .in(ar), .in_valid(ar_valid), .in_ready(ar_ready),
        .out(p_ar), .out_valid(p_ar_valid), .out_ready(p_ar_ready)
    );

    // Response channels run peripheral to controller
    axi4l_skid_buffer #(.payload_t(b_t), .cfg(cfg)) i_skid_b (
        .aclk(aclk), .rst_n(rst_n),
        .in(p_b), .in_valid(p_b_valid), .in_ready(p_b_ready),
        .out(b), .out_valid(b_valid), .out_ready(b_ready)
    );

    axi4l_skid_buffer #(.payload_t(r_t), .cfg(cfg)) i_skid_r (
        .aclk(aclk), .rst_n(rst_n),
        .in(p_r), .in_valid(p_r_valid), .in_ready(p_r_ready),
        .out(r), .out_valid(r_valid), .out_ready(r_ready)
    );

    generate
        if (reset_stages[cfg] == 0) begin : g_rst_direct
            assign p_rst_n = rst_n;
        end else begin : g_rst_pipe
            logic [reset_stages[cfg]-1:0] rst_pipe;

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    rst_pipe <= '0;  // Assert at once
                end else begin
                    rst_pipe[0] <= 1'b1;
                    for (int i = 1; i < reset_stages[cfg]; i++) begin
                        rst_pipe[i] <= rst_pipe[i-1];
                    end
                end
            end

            assign p_rst_n = rst_pipe[reset_stages[cfg]-1];
        end
    endgenerate

endmodule : axi4l_reg_slice

// ==== logic/axi4l_reg_file.sv ====
`timescale 1ns/1ns

module axi4l_reg_file
    import axi4l_pkg::*;
(
    input  logic aclk,
    input  logic rst_n,
    input  ax_t  aw,
    input  logic aw_valid,
    output logic aw_ready,
    input  w_t   w,
    input  logic w_valid,
    output logic w_ready,
    output b_t   b,
    output logic b_valid,
    input  logic b_ready,
    input  ax_t  ar,
    input  logic ar_valid,
    output logic ar_ready,
    output r_t   r,
    output logic r_valid,
    input  logic r_ready
);

    logic                   aw_held;
    logic                   w_held;
    ax_t                    aw_q;
    w_t                     w_q;
    ax_t                    wr_ax;
    w_t                     wr_d;
    logic                   aw_xfer;
    logic                   w_xfer;
    logic                   ar_xfer;
    logic                   wr_fire;
    logic                   wr_ok;
    logic                   rd_in_map;
    logic [reg_idx_wid-1:0] wr_idx;
    logic [reg_idx_wid-1:0] rd_idx;
    logic [data_wid-1:0]    rd_data;
    resp_t                  rd_resp;
    logic [data_wid-1:0]    regs [1:reg_count-1];

    assign aw_ready = !aw_held && !b_valid;
    assign w_ready  = !w_held && !b_valid;
    assign ar_ready = !r_valid;

    assign aw_xfer = aw_valid && aw_ready;
    assign w_xfer  = w_valid && w_ready;
    assign ar_xfer = ar_valid && ar_ready;

    // Write runs once both halves are here, held or arriving now
    assign wr_fire = (aw_held || aw_xfer) && (w_held || w_xfer);
    assign wr_ax   = aw_held ? aw_q : aw;
    assign wr_d    = w_held ? w_q : w;
    assign wr_idx  = wr_ax.addr[reg_idx_wid+1:2];
    assign wr_ok   = (wr_ax.addr[addr_wid-1:reg_idx_wid+2] == '0) && (wr_idx != '0);

    assign rd_idx    = ar.addr[reg_idx_wid+1:2];
    assign rd_in_map = (ar.addr[addr_wid-1:reg_idx_wid+2] == '0);

    always_comb begin
        rd_data = '0;
        rd_resp = resp_slverr;
        if (rd_in_map) begin
            rd_resp = resp_okay;
            if (rd_idx == '0) begin
                rd_data = reg_id_value;
            end
            for (int k = 1; k < reg_count; k++) begin
                if (rd_idx == reg_idx_wid'(k)) begin
                    rd_data = regs[k];
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                b_valid <= 1'b1;
            end else begin
                if (aw_xfer) aw_held <= 1'b1;
                if (w_xfer) w_held <= 1'b1;
                if (b_ready) b_valid <= 1'b0;
            end
            if (ar_xfer) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < reg_count; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_fire && wr_ok) begin
            for (int k = 1; k < reg_count; k++) begin
                for (int i = 0; i < strb_wid; i++) begin
                    if (wr_idx == reg_idx_wid'(k) && wr_d.strb[i]) begin
                        regs[k][8*i +: 8] <= wr_d.data[8*i +: 8];  // Byte merge
                    end
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_xfer) aw_q <= aw;
        if (w_xfer) w_q <= w;
        if (wr_fire) b.resp <= wr_ok ? resp_okay : resp_slverr;
        if (ar_xfer) begin
            r.data <= rd_data;
            r.resp <= rd_resp;
        end
    end

endmodule : axi4l_reg_file

// ==== logic/axi4l_reg_subsystem.sv ====
`timescale 1ns/1ns

module axi4l_reg_subsystem
    import axi4l_pkg::*;
(
    input  logic aclk,
    input  logic rst_n,
    input  ax_t  aw,
    input  logic aw_valid,
    output logic aw_ready,
    input  w_t   w,
    input  logic w_valid,
    output logic w_ready,
    output b_t   b,
    output logic b_valid,
    input  logic b_ready,
    input  ax_t  ar,
    input  logic ar_valid,
    output logic ar_ready,
    output r_t   r,
    output logic r_valid,
    input  logic r_ready
);

    ax_t  p_aw;
    ax_t  p_ar;
    w_t   p_w;
    b_t   p_b;
    r_t   p_r;
    logic p_aw_valid, p_aw_ready, p_w_valid, p_w_ready;
    logic p_b_valid, p_b_ready, p_ar_valid, p_ar_ready;
    logic p_r_valid, p_r_ready;
    logic p_rst_n;  // Delayed release from the slice

    axi4l_reg_slice #(.cfg(slice_full)) i_axi4l_reg_slice (
        .aclk(aclk), .rst_n(rst_n),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .p_aw(p_aw), .p_aw_valid(p_aw_valid), .p_aw_ready(p_aw_ready),
        .p_w(p_w), .p_w_valid(p_w_valid), .p_w_ready(p_w_ready),
        .p_b(p_b), .p_b_valid(p_b_valid), .p_b_ready(p_b_ready),
        .p_ar(p_ar), .p_ar_valid(p_ar_valid), .p_ar_ready(p_ar_ready),
        .p_r(p_r), .p_r_valid(p_r_valid), .p_r_ready(p_r_ready),
        .p_rst_n(p_rst_n)
    );

    axi4l_reg_file i_axi4l_reg_file (
        .aclk(aclk), .rst_n(p_rst_n),
        .aw(p_aw), .aw_valid(p_aw_valid), .aw_ready(p_aw_ready),
        .w(p_w), .w_valid(p_w_valid), .w_ready(p_w_ready),
        .b(p_b), .b_valid(p_b_valid), .b_ready(p_b_ready),
        .ar(p_ar), .ar_valid(p_ar_valid), .ar_ready(p_ar_ready),
        .r(p_r), .r_valid(p_r_valid), .r_ready(p_r_ready)
    );

endmodule : axi4l_reg_subsystem

// ==== verification/tb_axi4l_reg_subsystem.sv ====
`timescale 1ns/1ns

module tb_axi4l_reg_subsystem;
    import axi4l_pkg::*;

    logic aclk;
    logic rst_n;
    ax_t  aw;
    logic aw_valid;
    logic aw_ready;
    w_t   w;
    logic w_valid;
    logic w_ready;
    b_t   b;
    logic b_valid;
    logic b_ready;
    ax_t  ar;
    logic ar_valid;
    logic ar_ready;
    r_t   r;
    logic r_valid;
    logic r_ready;

    logic [data_wid-1:0] shadow [reg_count];  // Expected register contents
    b_t          exp_b_q [$];
    r_t          exp_r_q [$];
    int          b_issued = 0;
    int          r_issued = 0;
    int          b_seen = 0;
    int          r_seen = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    logic [31:0] data_state;
    logic [31:0] stall_state;
    logic        stall_en;

    axi4l_reg_subsystem i_axi4l_reg_subsystem (.*);

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    function automatic logic [31:0] lcg(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return {state[15:0], state[31:16]};  // Better bits go low
    endfunction

    function automatic ax_t to_ax(input logic [31:0] addr);
        return ax_t'({addr, 3'b000});
    endfunction

    function automatic w_t to_w(input logic [31:0] data, input logic [3:0] strb);
        return w_t'({data, strb});
    endfunction

    function automatic r_t model_access(input logic wr, input ax_t a, input w_t d);
        r_t         res;
        logic [2:0] idx;
        logic       in_map;
        idx      = a.addr[4:2];
        in_map   = (a.addr[31:5] == '0);
        res.data = '0;
        res.resp = in_map ? resp_okay : resp_slverr;
        if (wr) begin
            if (!in_map || idx == 3'd0) begin
                res.resp = resp_slverr;  // ID word is read-only
            end else begin
                for (int i = 0; i < strb_wid; i++) begin
                    if (d.strb[i]) shadow[idx][8*i +: 8] = d.data[8*i +: 8];
                end
            end
        end else if (in_map) begin
            res.data = (idx == 3'd0) ? reg_id_value : shadow[idx];
        end
        return res;
    endfunction

    task automatic check_b(input b_t exp, input b_t act);
        if (act === exp) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("ERR b: expected %h, actual %h", exp, act);
        end
    endtask

    task automatic check_r(input r_t exp, input r_t act);
        if (act === exp) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("ERR r: expected %h, actual %h", exp, act);
        end
    endtask

    task automatic check_int(input string name, input int exp, input int act);
        if (act === exp) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Responses are checked in the cycle before the transfer edge
    always @(negedge aclk) begin
        if (rst_n && b_valid && b_ready) begin
            if (exp_b_q.size() == 0) begin
                fail_count++;
                $display("A write response arrived with no write outstanding");
            end else begin
                check_b(exp_b_q.pop_front(), b);
            end
            b_seen++;
        end
        if (rst_n && r_valid && r_ready) begin
            if (exp_r_q.size() == 0) begin
                fail_count++;
                $display("A read response arrived with no read outstanding");
            end else begin
                check_r(exp_r_q.pop_front(), r);
            end
            r_seen++;
        end
    end

    always @(posedge aclk) begin
        logic [31:0] x;
        #2;
        x       = lcg(stall_state);
        b_ready = !stall_en || x[0];
        r_ready = !stall_en || x[1];
    end

    task automatic send_aw(input ax_t a);
        aw       = a;
        aw_valid = 1'b1;
        @(negedge aclk);
        while (!aw_ready) @(negedge aclk);
        @(posedge aclk);
        #2;
        aw_valid = 1'b0;
    endtask

    task automatic send_w(input w_t d);
        w       = d;
        w_valid = 1'b1;
        @(negedge aclk);
        while (!w_ready) @(negedge aclk);
        @(posedge aclk);
        #2;
        w_valid = 1'b0;
    endtask

    task automatic send_ar(input ax_t a);
        ar       = a;
        ar_valid = 1'b1;
        @(negedge aclk);
        while (!ar_ready) @(negedge aclk);
        @(posedge aclk);
        #2;
        ar_valid = 1'b0;
    endtask

    task automatic wait_done();
        wait (b_seen >= b_issued && r_seen >= r_issued);
        @(posedge aclk);
        #2;
    endtask

    // Order 0 sends aw first, 1 sends w first, 2 sends both together
    task automatic axi_write(input ax_t a, input w_t d, input int order);
        r_t e;
        e = model_access(1'b1, a, d);
        exp_b_q.push_back(b_t'(e.resp));
        b_issued++;
        case (order)
            0: begin
                send_aw(a);
                send_w(d);
            end
            1: begin
                send_w(d);
                send_aw(a);
            end
            default: begin
                fork
                    send_aw(a);
                    send_w(d);
                join
            end
        endcase
        wait_done();
    endtask

    task automatic axi_read(input ax_t a, input logic wait_resp, input logic check_lat);
        int lat;
        exp_r_q.push_back(model_access(1'b0, a, '0));
        r_issued++;
        send_ar(a);
        if (check_lat) begin
            lat = 1;  // Transfer edge counts as the first cycle
            while (!r_valid) begin
                @(posedge aclk);
                #2;
                lat++;
            end
            check_int("r_valid latency", 3, lat);
        end
        if (wait_resp) wait_done();
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, fail_count - fails_before);
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 200 * (b_issued + r_issued) + 100) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a handshake or response never came", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int          fails_before;
        logic [31:0] x;
        logic [31:0] d;
        logic [31:0] idx;
        aw          = '0;
        aw_valid    = 1'b0;
        w           = '0;
        w_valid     = 1'b0;
        ar          = '0;
        ar_valid    = 1'b0;
        b_ready     = 1'b1;
        r_ready     = 1'b1;
        stall_en    = 1'b0;
        data_state  = 32'd76;
        stall_state = 32'd76;
        for (int i = 0; i < reg_count; i++) shadow[i] = '0;
        rst_n = 1'b0;
        repeat (5) @(posedge aclk);
        #2;
        rst_n = 1'b1;
        repeat (4) @(posedge aclk);  // Peripheral reset release
        #2;

        fails_before = fail_count;
        check_int("b_valid", 0, int'(b_valid));
        check_int("r_valid", 0, int'(r_valid));
        for (int i = 0; i < reg_count; i++) axi_read(to_ax(4 * i), 1'b1, 1'b0);
        report_test("reset values", fails_before);

        fails_before = fail_count;
        for (int i = 1; i < reg_count; i++) begin
            axi_write(to_ax(4 * i), to_w(lcg(data_state), 4'hf), 2);
            axi_read(to_ax(4 * i), 1'b1, 1'b1);
        end
        report_test("full-word write and read", fails_before);

        fails_before = fail_count;
        repeat (24) begin
            x   = lcg(data_state);
            idx = x % 32'd7 + 32'd1;
            axi_write(to_ax(4 * idx), to_w(lcg(data_state), x[11:8]), 2);
            axi_read(to_ax(4 * idx), 1'b1, 1'b0);
        end
        report_test("byte strobes", fails_before);

        fails_before = fail_count;
        axi_write(to_ax(32'h0), to_w(lcg(data_state), 4'hf), 2);
        axi_write(to_ax(32'h20), to_w(lcg(data_state), 4'hf), 0);
        axi_write(to_ax(32'h1000_0004), to_w(lcg(data_state), 4'hf), 1);
        for (int i = 0; i < reg_count; i++) axi_read(to_ax(4 * i), 1'b1, 1'b0);
        axi_read(to_ax(32'h24), 1'b1, 1'b0);
        axi_read(to_ax((lcg(data_state) | 32'h20) & ~32'h3), 1'b1, 1'b0);
        report_test("slverr cases", fails_before);

        fails_before = fail_count;
        for (int order = 0; order < 3; order++) begin
            for (int i = 1; i < reg_count; i++) begin
                d = lcg(data_state);
                axi_write(to_ax(4 * i), to_w(d, 4'hf), order);
                axi_read(to_ax(4 * i), 1'b1, 1'b0);
            end
        end
        report_test("aw and w order", fails_before);

        fails_before = fail_count;
        stall_en = 1'b1;
        repeat (4) begin
            x = lcg(data_state);
            axi_write(to_ax(x & 32'h1c), to_w(lcg(data_state), x[11:8]), 2);
        end
        repeat (16) axi_read(to_ax(lcg(data_state) & 32'h3c), 1'b0, 1'b0);
        wait_done();
        stall_en = 1'b0;
        repeat (8) @(posedge aclk);  // Window for any duplicate response
        #2;
        check_int("b responses", b_issued, b_seen);
        check_int("r responses", r_issued, r_seen);
        report_test("response stalls", fails_before);

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_axi4l_reg_subsystem

// ==== tb.f ====
common/axi4l_pkg.sv
reg_slice/axi4l_skid_buffer.sv
reg_slice/axi4l_reg_slice.sv
logic/axi4l_reg_file.sv
logic/axi4l_reg_subsystem.sv
verification/tb_axi4l_reg_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the AXI4-Lite register subsystem testbench

TOOL       := verilator
TOP        := tb_axi4l_reg_subsystem
FILELIST   := tb.f
FLAGS      := --binary --timing -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
BUILD_DIR  := obj_dir
LOG        := run.log
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
